// File: source/video_timing_pkg.sv
package video_timing_pkg;

  // default raster is 720p60
  localparam int H_ACTIVE_DEF = 1280;  // visible pixels per line
  localparam int V_ACTIVE_DEF = 720;   // visible lines per frame

  // horizontal blanking, in pixels
  localparam int H_FRONT_DEF = 110;
  localparam int H_SYNC_DEF  = 40;
  localparam int H_BACK_DEF  = 220;

  // vertical blanking, in lines
  localparam int V_FRONT_DEF = 5;
  localparam int V_SYNC_DEF  = 5;
  localparam int V_BACK_DEF  = 20;

  // position counter widths, wide enough for the full 720p totals
  localparam int HPOS_W = 12;  // up to 4095 columns
  localparam int VPOS_W = 11;  // up to 2047 lines

  // cycles from pixel accept to the mask stage output
  localparam int PIPE_DEPTH = 4;

endpackage

// File: source/pixel_format_pkg.sv
package pixel_format_pkg;

  localparam int PIX565_W = 16;        // incoming rgb565 word
  localparam int CH_W     = 8;         // one expanded channel
  localparam int RGB_W    = 3 * CH_W;  // packed r,g,b

  // shown in place of a pixel that arrives without valid
  localparam logic [PIX565_W-1:0] FILL_COLOR = 16'h2277;

  // display modes, picked by sw[5:4]
  localparam logic [1:0] MODE_CAMERA  = 2'd0;
  localparam logic [1:0] MODE_LUMA    = 2'd1;
  localparam logic [1:0] MODE_MASK    = 2'd2;
  localparam logic [1:0] MODE_OVERLAY = 2'd3;

  localparam logic [RGB_W-1:0] OVERLAY_COLOR = 24'hff00ff;  // magenta

  // bt.601 coefficients scaled by 256, signs applied in color_convert
  localparam int Y_R  = 66;
  localparam int Y_G  = 129;
  localparam int Y_B  = 25;
  localparam int CB_R = 38;   // subtracted
  localparam int CB_G = 74;   // subtracted
  localparam int CB_B = 112;
  localparam int CR_R = 112;
  localparam int CR_G = 94;   // subtracted
  localparam int CR_B = 18;   // subtracted

  localparam int ROUND_C = 128;  // half lsb before the >> 8
  localparam int Y_OFS   = 16;
  localparam int C_OFS   = 128;

  localparam int BIN_MAJORITY = 2;  // ones needed out of a 2x2 block

endpackage

// File: source/raster_timing.sv
`timescale 1ns/1ps
`default_nettype none

module raster_timing import video_timing_pkg::*; #(
  parameter int H_ACTIVE = H_ACTIVE_DEF,
  parameter int V_ACTIVE = V_ACTIVE_DEF,
  parameter int H_FRONT  = H_FRONT_DEF,
  parameter int H_SYNC   = H_SYNC_DEF,
  parameter int H_BACK   = H_BACK_DEF,
  parameter int V_FRONT  = V_FRONT_DEF,
  parameter int V_SYNC   = V_SYNC_DEF,
  parameter int V_BACK   = V_BACK_DEF
) (
  input  logic              clk_pixel,
  input  logic              sys_rst_pixel,
  input  logic              pixel_tlast_i,
  output logic              pixel_ready_o,
  output logic              accept_o,     // pixel taken this cycle
  output logic [HPOS_W-1:0] hpos_d_o,     // everything *_d_o is PIPE_DEPTH late
  output logic [VPOS_W-1:0] vpos_d_o,
  output logic              active_d_o,
  output logic              hsync_d_o,
  output logic              vsync_d_o,
  output logic              accept_d_o
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam logic [HPOS_W-1:0] H_LAST = HPOS_W'(H_TOTAL - 1);
  localparam logic [VPOS_W-1:0] V_LAST = VPOS_W'(V_TOTAL - 1);

  logic [HPOS_W-1:0] hcount;
  logic [VPOS_W-1:0] vcount;
  logic              running;  // low for one cycle after reset, raster held at 0,0
  logic              active;
  logic              hsync;
  logic              vsync;
  logic              at_last;  // last visible pixel of the frame

  logic [3:0]        ctrl_pipe [PIPE_DEPTH];  // {accept, active, hsync, vsync}
  logic [HPOS_W-1:0] hpos_pipe [PIPE_DEPTH];
  logic [VPOS_W-1:0] vpos_pipe [PIPE_DEPTH];

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      hcount  <= '0;
      vcount  <= '0;
      running <= 1'b0;
    end else begin
      running <= 1'b1;
      if (running) begin
        if (hcount == H_LAST) begin
          hcount <= '0;
          vcount <= (vcount == V_LAST) ? '0 : vcount + 1'b1;  // wrap at frame end
        end else begin
          hcount <= hcount + 1'b1;
        end
      end
    end
  end

  assign active  = running && (hcount < HPOS_W'(H_ACTIVE)) && (vcount < VPOS_W'(V_ACTIVE));
  assign hsync   = (hcount >= HPOS_W'(H_ACTIVE + H_FRONT)) &&
                   (hcount < HPOS_W'(H_ACTIVE + H_FRONT + H_SYNC));
  assign vsync   = (vcount >= VPOS_W'(V_ACTIVE + V_FRONT)) &&
                   (vcount < VPOS_W'(V_ACTIVE + V_FRONT + V_SYNC));
  assign at_last = (hcount == HPOS_W'(H_ACTIVE - 1)) && (vcount == VPOS_W'(V_ACTIVE - 1));

  // an early tlast stalls the source until the raster catches up with it
  assign pixel_ready_o = active && (!pixel_tlast_i || at_last);
  assign accept_o      = pixel_ready_o;  // no back-pressure, ready alone takes the pixel

  // control half of the delay line
  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      for (int i = 0; i < PIPE_DEPTH; i++) begin
        ctrl_pipe[i] <= '0;
      end
    end else begin
      ctrl_pipe[0] <= {accept_o, active, hsync, vsync};
      for (int i = 1; i < PIPE_DEPTH; i++) begin
        ctrl_pipe[i] <= ctrl_pipe[i-1];
      end
    end
  end

  // position half, only meaningful when the matching accept is set
  always_ff @(posedge clk_pixel) begin
    hpos_pipe[0] <= hcount;
    vpos_pipe[0] <= vcount;
    for (int i = 1; i < PIPE_DEPTH; i++) begin
      hpos_pipe[i] <= hpos_pipe[i-1];
      vpos_pipe[i] <= vpos_pipe[i-1];
    end
  end

  assign {accept_d_o, active_d_o, hsync_d_o, vsync_d_o} = ctrl_pipe[PIPE_DEPTH-1];
  assign hpos_d_o = hpos_pipe[PIPE_DEPTH-1];
  assign vpos_d_o = vpos_pipe[PIPE_DEPTH-1];

  a_count_range: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    (hcount <= H_LAST) && (vcount <= V_LAST));

  // a taken pixel must still be inside active draw when it reaches the mask stage
  a_ready_active: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    pixel_ready_o |-> ##PIPE_DEPTH active_d_o);

endmodule

`default_nettype wire

// File: source/color_convert.sv
`timescale 1ns/1ps
`default_nettype none

module color_convert import pixel_format_pkg::*; (
  input  logic                clk_pixel,
  input  logic                pixel_valid_i,
  input  logic [PIX565_W-1:0] pixel_data_i,
  input  logic                accept_i,
  output logic [RGB_W-1:0]    rgb_o,   // lines up with y/cr/cb, t+3
  output logic [CH_W-1:0]     y_o,
  output logic [CH_W-1:0]     cr_o,
  output logic [CH_W-1:0]     cb_o
);

  logic [PIX565_W-1:0] pix;
  logic [CH_W-1:0]     r1, g1, b1;  // expanded channels, t+1
  logic [RGB_W-1:0]    rgb2;
  logic [15:0]         yr_p, yg_p, yb_p;  // products, t+2
  logic [15:0]         cbr_p, cbg_p, cbb_p;
  logic [15:0]         crr_p, crg_p, crb_p;
  logic signed [17:0]  y_sum, cb_sum, cr_sum;

  function automatic logic [CH_W-1:0] clamp_ch(input logic signed [17:0] v);
    if (v < 0) return '0;
    if (v > 255) return '1;
    return v[CH_W-1:0];
  endfunction

  assign pix = pixel_valid_i ? pixel_data_i : FILL_COLOR;  // fill when source has nothing

  // stage 1, pad low bits with zeros
  always_ff @(posedge clk_pixel) begin
    if (accept_i) begin
      r1 <= {pix[15:11], 3'b000};
      g1 <= {pix[10:5], 2'b00};
      b1 <= {pix[4:0], 3'b000};
    end
  end

  // stage 2, the nine multiplies
  always_ff @(posedge clk_pixel) begin
    yr_p  <= 16'(Y_R * r1);
    yg_p  <= 16'(Y_G * g1);
    yb_p  <= 16'(Y_B * b1);
    cbr_p <= 16'(CB_R * r1);
    cbg_p <= 16'(CB_G * g1);
    cbb_p <= 16'(CB_B * b1);
    crr_p <= 16'(CR_R * r1);
    crg_p <= 16'(CR_G * g1);
    crb_p <= 16'(CR_B * b1);
    rgb2  <= {r1, g1, b1};
  end

  // chroma sums can go negative, 18 bits signed holds the full range
  always_comb begin
    y_sum  = 18'(yr_p) + 18'(yg_p) + 18'(yb_p) + 18'(ROUND_C);
    cb_sum = 18'(cbb_p) - 18'(cbr_p) - 18'(cbg_p) + 18'(ROUND_C);
    cr_sum = 18'(crr_p) - 18'(crg_p) - 18'(crb_p) + 18'(ROUND_C);
  end

  // stage 3, scale down, offset, clamp
  always_ff @(posedge clk_pixel) begin
    y_o   <= clamp_ch((y_sum >>> 8) + $signed(18'(Y_OFS)));
    cb_o  <= clamp_ch((cb_sum >>> 8) + $signed(18'(C_OFS)));  // arithmetic shift floors
    cr_o  <= clamp_ch((cr_sum >>> 8) + $signed(18'(C_OFS)));
    rgb_o <= rgb2;
  end

endmodule

`default_nettype wire

// File: source/mask_threshold.sv
`timescale 1ns/1ps
`default_nettype none

module mask_threshold import pixel_format_pkg::*; (
  input  logic             clk_pixel,
  input  logic [15:0]      sw_i,
  input  logic [CH_W-1:0]  y_i,
  input  logic [CH_W-1:0]  cr_i,
  input  logic [CH_W-1:0]  cb_i,
  input  logic [RGB_W-1:0] rgb_i,
  output logic             mask_o,  // all three channels at or above cutoff
  output logic [CH_W-1:0]  y_o,     // delayed to stay with the mask
  output logic [RGB_W-1:0] rgb_o
);

  logic [CH_W-1:0] y_cut;
  logic [CH_W-1:0] cr_cut;
  logic [CH_W-1:0] cb_cut;

  // coarse cutoffs straight off the switches
  assign cr_cut = {sw_i[11:8], 4'b0000};
  assign cb_cut = {sw_i[15:12], 4'b0000};
  assign y_cut  = {sw_i[7:6], sw_i[3:1], 3'b000};  // sw[5:4] is the display mode

  always_ff @(posedge clk_pixel) begin
    mask_o <= (y_i >= y_cut) && (cr_i >= cr_cut) && (cb_i >= cb_cut);
    y_o    <= y_i;
    rgb_o  <= rgb_i;
  end

endmodule

`default_nettype wire

// File: source/mask_binner.sv
`timescale 1ns/1ps
`default_nettype none

module mask_binner import video_timing_pkg::*, pixel_format_pkg::*; #(
  parameter int H_ACTIVE = H_ACTIVE_DEF
) (
  input  logic              clk_pixel,
  input  logic              sys_rst_pixel,
  input  logic              mask_i,
  input  logic              valid_i,      // delayed accept
  input  logic [HPOS_W-1:0] hpos_i,
  input  logic [VPOS_W-1:0] vpos_i,
  output logic              bin_valid_o,
  output logic              bin_bit_o,    // majority of the 2x2 block
  output logic [HPOS_W-2:0] bin_h_o,      // block column
  output logic [VPOS_W-2:0] bin_v_o       // block row
);

  localparam int LB_DEPTH = H_ACTIVE / 2;
  localparam int LB_AW    = (LB_DEPTH > 1) ? $clog2(LB_DEPTH) : 1;

  logic [1:0]       line_buf [LB_DEPTH];  // pair sums from the even row above
  logic             left_q;               // mask bit of the even column
  logic [1:0]       pair_sum;
  logic [2:0]       block_sum;
  logic [LB_AW-1:0] lb_addr;
  logic             pair_done;            // second pixel of a horizontal pair

  assign lb_addr   = hpos_i[LB_AW:1];
  assign pair_done = valid_i && hpos_i[0];
  assign pair_sum  = {1'b0, left_q} + {1'b0, mask_i};
  assign block_sum = {1'b0, line_buf[lb_addr]} + {1'b0, pair_sum};

  always_ff @(posedge clk_pixel) begin
    if (valid_i && !hpos_i[0]) begin
      left_q <= mask_i;
    end
    if (pair_done && !vpos_i[0]) begin
      line_buf[lb_addr] <= pair_sum;  // even row, park it for the next line
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      bin_valid_o <= 1'b0;
    end else begin
      bin_valid_o <= pair_done && vpos_i[0];  // odd column of an odd row closes a block
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (pair_done && vpos_i[0]) begin
      bin_bit_o <= (block_sum >= 3'(BIN_MAJORITY));
      bin_h_o   <= hpos_i[HPOS_W-1:1];
      bin_v_o   <= vpos_i[VPOS_W-1:1];
    end
  end

  // blocks close on odd columns only, so two reports are never adjacent
  a_bin_origin: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    bin_valid_o |=> !bin_valid_o);

endmodule

`default_nettype wire

// File: source/video_mux.sv
`timescale 1ns/1ps
`default_nettype none

module video_mux import pixel_format_pkg::*; (
  input  logic             clk_pixel,
  input  logic             sys_rst_pixel,
  input  logic [1:0]       mode_i,
  input  logic             mask_i,
  input  logic [CH_W-1:0]  y_i,
  input  logic [RGB_W-1:0] rgb_i,
  input  logic             active_i,
  input  logic             hsync_i,
  input  logic             vsync_i,
  output logic [CH_W-1:0]  red_o,
  output logic [CH_W-1:0]  green_o,
  output logic [CH_W-1:0]  blue_o,
  output logic             de_o,
  output logic             hsync_o,
  output logic             vsync_o
);

  logic [RGB_W-1:0] pix_sel;

  always_comb begin
    case (mode_i)
      MODE_CAMERA:  pix_sel = rgb_i;
      MODE_LUMA:    pix_sel = {y_i, y_i, y_i};            // grey from luma
      MODE_MASK:    pix_sel = {RGB_W{mask_i}};            // white where masked
      MODE_OVERLAY: pix_sel = mask_i ? OVERLAY_COLOR : rgb_i;
      default:      pix_sel = rgb_i;
    endcase
    if (!active_i) begin
      pix_sel = '0;  // black in blanking
    end
  end

  always_ff @(posedge clk_pixel) begin
    {red_o, green_o, blue_o} <= pix_sel;
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      de_o    <= 1'b0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
    end else begin
      de_o    <= active_i;
      hsync_o <= hsync_i;
      vsync_o <= vsync_i;
    end
  end

endmodule

`default_nettype wire

// File: source/mask_pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

module mask_pipeline_top import video_timing_pkg::*, pixel_format_pkg::*; #(
  parameter int H_ACTIVE = H_ACTIVE_DEF,
  parameter int V_ACTIVE = V_ACTIVE_DEF,
  parameter int H_FRONT  = H_FRONT_DEF,
  parameter int H_SYNC   = H_SYNC_DEF,
  parameter int H_BACK   = H_BACK_DEF,
  parameter int V_FRONT  = V_FRONT_DEF,
  parameter int V_SYNC   = V_SYNC_DEF,
  parameter int V_BACK   = V_BACK_DEF
) (
  input  logic                clk_pixel,
  input  logic                sys_rst_pixel,
  input  logic                pixel_valid_i,
  input  logic [PIX565_W-1:0] pixel_data_i,
  input  logic                pixel_tlast_i,
  input  logic [15:0]         sw_i,
  output logic                pixel_ready_o,
  output logic [CH_W-1:0]     red_o,
  output logic [CH_W-1:0]     green_o,
  output logic [CH_W-1:0]     blue_o,
  output logic                de_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                bin_valid_o,
  output logic                bin_bit_o,
  output logic [HPOS_W-2:0]   bin_h_o,
  output logic [VPOS_W-2:0]   bin_v_o
);

  logic              accept;                      // t
  logic [RGB_W-1:0]  rgb_c;                       // t+3
  logic [CH_W-1:0]   y_c, cr_c, cb_c;
  logic              mask_m;                      // t+4
  logic [CH_W-1:0]   y_m;
  logic [RGB_W-1:0]  rgb_m;
  logic [HPOS_W-1:0] hpos_d;                      // t+4 from the delay line
  logic [VPOS_W-1:0] vpos_d;
  logic              active_d, hsync_d, vsync_d, accept_d;

  raster_timing #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
    .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_timing (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .pixel_tlast_i(pixel_tlast_i),
    .pixel_ready_o(pixel_ready_o), .accept_o(accept),
    .hpos_d_o(hpos_d), .vpos_d_o(vpos_d), .active_d_o(active_d),
    .hsync_d_o(hsync_d), .vsync_d_o(vsync_d), .accept_d_o(accept_d)
  );

  color_convert u_convert (
    .clk_pixel(clk_pixel), .pixel_valid_i(pixel_valid_i), .pixel_data_i(pixel_data_i),
    .accept_i(accept), .rgb_o(rgb_c), .y_o(y_c), .cr_o(cr_c), .cb_o(cb_c)
  );

  mask_threshold u_threshold (
    .clk_pixel(clk_pixel), .sw_i(sw_i), .y_i(y_c), .cr_i(cr_c), .cb_i(cb_c),
    .rgb_i(rgb_c), .mask_o(mask_m), .y_o(y_m), .rgb_o(rgb_m)
  );

  mask_binner #(.H_ACTIVE(H_ACTIVE)) u_binner (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .mask_i(mask_m),
    .valid_i(accept_d), .hpos_i(hpos_d), .vpos_i(vpos_d), .bin_valid_o(bin_valid_o),
    .bin_bit_o(bin_bit_o), .bin_h_o(bin_h_o), .bin_v_o(bin_v_o)
  );

  video_mux u_mux (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .mode_i(sw_i[5:4]),
    .mask_i(mask_m), .y_i(y_m), .rgb_i(rgb_m), .active_i(active_d),
    .hsync_i(hsync_d), .vsync_i(vsync_d), .red_o(red_o), .green_o(green_o),
    .blue_o(blue_o), .de_o(de_o), .hsync_o(hsync_o), .vsync_o(vsync_o)
  );

endmodule

`default_nettype wire

// File: test/tb_mask_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mask_pipeline import video_timing_pkg::*, pixel_format_pkg::*; ();

  localparam int H_ACT         = 16;
  localparam int V_ACT         = 8;
  localparam int PORCH         = 2;  // front, sync and back porch alike
  localparam int H_TOT         = H_ACT + 3 * PORCH;
  localparam int V_TOT         = V_ACT + 3 * PORCH;
  localparam int FRAME_CYCLES  = H_TOT * V_TOT;
  localparam int N_FRAMES      = 8;
  localparam int CLK_PERIOD    = 100;
  localparam int MARGIN_CYCLES = 50;
  localparam int TIMEOUT_NS    = (N_FRAMES * FRAME_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
  localparam int DLY           = PIPE_DEPTH + 1;  // accept to registered output
  localparam logic [31:0] SEED = 32'hd67fb6e4;

  logic                clk_pixel;
  logic                sys_rst_pixel;
  logic                pixel_valid_i;
  logic [PIX565_W-1:0] pixel_data_i;
  logic                pixel_tlast_i;
  logic [15:0]         sw_i;
  logic                pixel_ready_o;
  logic [CH_W-1:0]     red_o, green_o, blue_o;
  logic                de_o, hsync_o, vsync_o;
  logic                bin_valid_o, bin_bit_o;
  logic [HPOS_W-2:0]   bin_h_o;
  logic [VPOS_W-2:0]   bin_v_o;

  int chan_errs, bit_errs, coord_errs, other_errs;
  logic [31:0] rng;
  int h, v;                                // raster position seen by the next edge
  logic hist_act [DLY], hist_acc [DLY], hist_hs [DLY], hist_vs [DLY];
  int hist_h [DLY], hist_v [DLY];
  logic [PIX565_W-1:0] pix_q [$];          // accepted pixels, fill already applied
  logic [RGB_W-1:0] last_exp;              // held output while the source stalls
  logic mask_grid [V_ACT][H_ACT];
  logic acc_grid [V_ACT][H_ACT];
  int src_count, frame_len, frame_idx;
  int acc_cnt, de_cnt, bin_cnt, last_ready_cnt, stall_cnt;
  logic stall_frame, waiting, act, exp_ready;

  mask_pipeline_top #(
    .H_ACTIVE(H_ACT), .V_ACTIVE(V_ACT),
    .H_FRONT(PORCH), .H_SYNC(PORCH), .H_BACK(PORCH),
    .V_FRONT(PORCH), .V_SYNC(PORCH), .V_BACK(PORCH)
  ) u_dut (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .pixel_valid_i(pixel_valid_i),
    .pixel_data_i(pixel_data_i), .pixel_tlast_i(pixel_tlast_i), .sw_i(sw_i),
    .pixel_ready_o(pixel_ready_o), .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .de_o(de_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .bin_valid_o(bin_valid_o),
    .bin_bit_o(bin_bit_o), .bin_h_o(bin_h_o), .bin_v_o(bin_v_o)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic int clamp255(input int x);
    if (x < 0) return 0;
    if (x > 255) return 255;
    return x;
  endfunction

  // bt.601 on the zero padded channels, >>> floors negative sums
  function automatic void to_ycc(input logic [PIX565_W-1:0] p, output int y, output int cb,
                                 output int cr);
    int r, g, b;
    r  = int'(p[15:11]) * 8;
    g  = int'(p[10:5]) * 4;
    b  = int'(p[4:0]) * 8;
    y  = clamp255(((66 * r + 129 * g + 25 * b + 128) >>> 8) + 16);
    cb = clamp255(((-38 * r - 74 * g + 112 * b + 128) >>> 8) + 128);
    cr = clamp255(((112 * r - 94 * g - 18 * b + 128) >>> 8) + 128);
  endfunction

  function automatic logic mask_of(input logic [PIX565_W-1:0] p, input logic [15:0] sw);
    int y, cb, cr;
    to_ycc(p, y, cb, cr);
    return (y >= int'({sw[7:6], sw[3:1], 3'b000})) &&
           (cr >= int'({sw[11:8], 4'b0000})) && (cb >= int'({sw[15:12], 4'b0000}));
  endfunction

  function automatic logic [RGB_W-1:0] expected_rgb(input logic [PIX565_W-1:0] p,
                                                    input logic [15:0] sw);
    int y, cb, cr;
    logic [RGB_W-1:0] rgb;
    to_ycc(p, y, cb, cr);
    rgb = {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    case (sw[5:4])
      MODE_LUMA:    return {8'(y), 8'(y), 8'(y)};
      MODE_MASK:    return mask_of(p, sw) ? 24'hffffff : 24'h000000;
      MODE_OVERLAY: return mask_of(p, sw) ? 24'hff00ff : rgb;
      default:      return rgb;
    endcase
  endfunction

  task automatic check_channel(input string name, input logic [CH_W-1:0] got,
                               input logic [CH_W-1:0] exp);
    if (got !== exp) begin
      chan_errs++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_coord(input string name, input logic [HPOS_W-2:0] got,
                             input logic [HPOS_W-2:0] exp);
    if (got !== exp) begin
      coord_errs++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic note_failure(input string msg);
    other_errs++;
    $display("frame %0d: %s", frame_idx, msg);
  endtask

  task automatic print_counts();
    $display("channel errors %0d, bit errors %0d, coordinate errors %0d, other errors %0d",
             chan_errs, bit_errs, coord_errs, other_errs);
  endtask

  task automatic check_idle();
    check_bit("pixel_ready_o", pixel_ready_o, 1'b0);
    check_bit("de_o", de_o, 1'b0);
    check_bit("bin_valid_o", bin_valid_o, 1'b0);
    check_bit("hsync_o", hsync_o, 1'b0);
    check_bit("vsync_o", vsync_o, 1'b0);
  endtask

  task automatic set_switches(input logic [1:0] mode);
    rng  = xorshift32(rng);
    sw_i = {4'(rng[3:0] % 10), 4'(rng[7:4] % 10), rng[9:8], mode, rng[12:10], rng[13]};
  endtask

  // compares what the DUT registered against the entry from DLY cycles back
  task automatic check_outputs();
    logic [RGB_W-1:0] exp_rgb;
    logic [HPOS_W-2:0] exp_h, exp_v;
    int bh, bv, ones;
    exp_rgb = '0;  // black outside active draw
    bh = hist_h[DLY-1];
    bv = hist_v[DLY-1];
    check_bit("de_o", de_o, hist_act[DLY-1]);
    check_bit("hsync_o", hsync_o, hist_hs[DLY-1]);
    check_bit("vsync_o", vsync_o, hist_vs[DLY-1]);
    if (hist_act[DLY-1]) begin
      if (hist_acc[DLY-1]) begin
        if (pix_q.size() == 0) note_failure("model queue empty at an accepted output pixel");
        else last_exp = expected_rgb(pix_q.pop_front(), sw_i);
      end
      exp_rgb = last_exp;  // a skipped position repeats the last taken pixel
    end
    if (de_o) de_cnt++;
    check_channel("red_o", red_o, exp_rgb[23:16]);
    check_channel("green_o", green_o, exp_rgb[15:8]);
    check_channel("blue_o", blue_o, exp_rgb[7:0]);
    check_bit("bin_valid_o", bin_valid_o, hist_acc[DLY-1] && bh[0] && bv[0]);
    if (bin_valid_o) bin_cnt++;
    // value checks only for blocks whose four pixels were all taken
    if (hist_acc[DLY-1] && bh[0] && bv[0] && acc_grid[bv-1][bh-1] && acc_grid[bv-1][bh] &&
        acc_grid[bv][bh-1]) begin
      ones = int'(mask_grid[bv-1][bh-1]) + int'(mask_grid[bv-1][bh]) +
             int'(mask_grid[bv][bh-1]) + int'(mask_grid[bv][bh]);
      exp_h = bh[HPOS_W-1:1];
      exp_v = {1'b0, bv[VPOS_W-1:1]};
      check_bit("bin_bit_o", bin_bit_o, ones >= 2);
      check_coord("bin_h_o", bin_h_o, exp_h);
      check_coord("bin_v_o", {1'b0, bin_v_o}, exp_v);
    end
  endtask

  // new random pixel each cycle, except a last flag is held until taken
  task automatic drive_source();
    if (!waiting) begin
      rng           = xorshift32(rng);
      pixel_data_i  = rng[15:0];
      pixel_valid_i = (rng[31:29] != 3'd0);  // about one in eight cycles without valid
      pixel_tlast_i = (src_count == frame_len - 1);
    end
  endtask

  task automatic close_frame();
    if (!stall_frame) begin
      if (de_cnt != acc_cnt) note_failure($sformatf("%0d de cycles for %0d accepted pixels",
                                                    de_cnt, acc_cnt));
      if (bin_cnt != (H_ACT / 2) * (V_ACT / 2))
        note_failure($sformatf("%0d bin reports instead of %0d", bin_cnt,
                               (H_ACT / 2) * (V_ACT / 2)));
    end else if (stall_cnt == 0) begin
      note_failure("early last flag never held the source back");
    end
    if (acc_cnt != frame_len)
      note_failure($sformatf("%0d pixels taken, source sent %0d", acc_cnt, frame_len));
    if (last_ready_cnt != 1)
      note_failure($sformatf("ready high %0d times under the last flag", last_ready_cnt));
    frame_idx++;
    acc_cnt = 0;
    de_cnt = 0;
    bin_cnt = 0;
    last_ready_cnt = 0;
    stall_cnt = 0;
    stall_frame = (frame_idx % 3 == 2);
    rng = xorshift32(rng);
    frame_len = stall_frame ? 64 + int'(rng[7:0]) % 60 : H_ACT * V_ACT;  // short frame stalls
    set_switches(2'(frame_idx % 4));
  endtask

  initial begin
    sys_rst_pixel = 1'b1;
    pixel_valid_i = 1'b0;
    pixel_data_i  = '0;
    pixel_tlast_i = 1'b0;
    rng = SEED;
    {chan_errs, bit_errs, coord_errs, other_errs} = '0;
    {src_count, frame_idx, acc_cnt, de_cnt, bin_cnt, last_ready_cnt, stall_cnt} = '0;
    h = 0;
    v = 0;
    waiting = 1'b0;
    stall_frame = 1'b0;
    frame_len = H_ACT * V_ACT;
    last_exp = '0;
    for (int k = 0; k < DLY; k++) begin
      {hist_act[k], hist_acc[k], hist_hs[k], hist_vs[k]} = '0;
      hist_h[k] = 0;
      hist_v[k] = 0;
    end
    set_switches(MODE_CAMERA);
    repeat (3) begin
      @(negedge clk_pixel);
      check_idle();
    end
    sys_rst_pixel = 1'b0;
    #1;
    check_idle();  // raster still parked for one cycle
    while (frame_idx < N_FRAMES) begin
      @(negedge clk_pixel);
      check_outputs();
      for (int k = DLY - 1; k > 0; k--) begin
        hist_act[k] = hist_act[k-1];
        hist_acc[k] = hist_acc[k-1];
        hist_hs[k]  = hist_hs[k-1];
        hist_vs[k]  = hist_vs[k-1];
        hist_h[k]   = hist_h[k-1];
        hist_v[k]   = hist_v[k-1];
      end
      if (h == 0 && v == V_ACT + 1) close_frame();  // pipeline drained, switches may move
      if (h == 0 && v == 0) begin
        for (int r = 0; r < V_ACT; r++)
          for (int c = 0; c < H_ACT; c++) acc_grid[r][c] = 1'b0;
      end
      drive_source();
      #1;
      act = (h < H_ACT) && (v < V_ACT);
      exp_ready = act && (!pixel_tlast_i || (h == H_ACT - 1 && v == V_ACT - 1));
      check_bit("pixel_ready_o", pixel_ready_o, exp_ready);
      if (pixel_ready_o) acc_cnt++;
      if (pixel_ready_o && pixel_tlast_i) last_ready_cnt++;
      if (exp_ready) begin
        pix_q.push_back(pixel_valid_i ? pixel_data_i : FILL_COLOR);
        acc_grid[v][h]  = 1'b1;
        mask_grid[v][h] = mask_of(pixel_valid_i ? pixel_data_i : FILL_COLOR, sw_i);
        if (pixel_tlast_i) begin
          src_count = 0;
        end else begin
          src_count++;
        end
        waiting = 1'b0;
      end else begin
        waiting = pixel_tlast_i;
        if (pixel_tlast_i && act && !pixel_ready_o) stall_cnt++;
      end
      hist_act[0] = act;
      hist_acc[0] = exp_ready;
      hist_hs[0]  = (h >= H_ACT + PORCH) && (h < H_ACT + 2 * PORCH);
      hist_vs[0]  = (v >= V_ACT + PORCH) && (v < V_ACT + 2 * PORCH);
      hist_h[0]   = h;
      hist_v[0]   = v;
      if (h == H_TOT - 1) begin
        h = 0;
        v = (v == V_TOT - 1) ? 0 : v + 1;
      end else begin
        h++;
      end
    end
    print_counts();
    if (chan_errs + bit_errs + coord_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns before all frames were checked", TIMEOUT_NS);
    print_counts();
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
source/video_timing_pkg.sv
source/pixel_format_pkg.sv
source/raster_timing.sv
source/color_convert.sv
source/mask_threshold.sv
source/mask_binner.sv
source/video_mux.sv
source/mask_pipeline_top.sv
test/tb_mask_pipeline.sv

// File: Makefile
TOP = tb_mask_pipeline

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f src.f

run: compile
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
